/* hdl/ipod_pkg.sv */
package ipod_pkg;

  // ============================================================
  // Shared types
  // ============================================================

  // Word address into the flash read port
  typedef logic [22:0] flash_addr_t;

  // One audio sample as sent to the codec path
  typedef logic [7:0] sample_t;

  // Sample period in CLK_50M cycles, also shown on the hex digits
  typedef logic [23:0] period_t;

  // One flash word, seen raw or as two 16-bit samples
  // halves[0] is played first in forward order
  typedef union packed {
    logic [31:0]      raw;
    logic [1:0][15:0] halves;
  } flash_word_u;

  // ============================================================
  // Keyboard command codes
  // ============================================================

  localparam logic [7:0] ascii_play_upper    = 8'h45;
  localparam logic [7:0] ascii_play_lower    = 8'h65;
  localparam logic [7:0] ascii_pause_upper   = 8'h44;
  localparam logic [7:0] ascii_pause_lower   = 8'h64;
  localparam logic [7:0] ascii_back_upper    = 8'h42;
  localparam logic [7:0] ascii_back_lower    = 8'h62;
  localparam logic [7:0] ascii_fwd_upper     = 8'h46;
  localparam logic [7:0] ascii_fwd_lower     = 8'h66;
  localparam logic [7:0] ascii_restart_upper = 8'h52;
  localparam logic [7:0] ascii_restart_lower = 8'h72;

endpackage

/* hdl/speed_control.sv */
`timescale 1ns/1ns

module speed_control #(
  parameter ipod_pkg::period_t default_count = 24'd2267,
  parameter ipod_pkg::period_t speed_step    = 24'd100,
  parameter ipod_pkg::period_t min_count     = 24'd100,
  parameter ipod_pkg::period_t max_count     = 24'd20000,
  parameter int unsigned       step_interval = 5_000_000
) (
  input  logic              CLK_50M,
  input  logic              rst_n,
  input  logic [2:0]        key,
  output ipod_pkg::period_t period_count
);

  localparam int cnt_w = $clog2(step_interval + 1);

  logic [2:0]        key_meta;
  logic [2:0]        key_sync;
  logic              up_press;
  logic              down_press;
  logic              reset_press;
  logic [cnt_w-1:0]  interval_cnt;
  ipod_pkg::period_t faster_count;
  ipod_pkg::period_t slower_count;

  // Two-stage synchroniser, buttons idle high
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      key_meta <= 3'b111;
      key_sync <= 3'b111;
    end
    else
    begin
      key_meta <= key;
      key_sync <= key_meta;
    end
  end

  assign up_press    = ~key_sync[0];
  assign down_press  = ~key_sync[1];
  assign reset_press = ~key_sync[2];

  // Clamped neighbours of the current count
  always_comb
  begin
    if (period_count < min_count + speed_step)
      faster_count = min_count;
    else
      faster_count = period_count - speed_step;

    if (period_count > max_count - speed_step)
      slower_count = max_count;
    else
      slower_count = period_count + speed_step;
  end

  // ============================================================
  // Period register with held-button repeat
  // ============================================================

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      interval_cnt <= '0;
      period_count <= default_count;
    end
    else if (reset_press)
    begin
      interval_cnt <= '0;
      period_count <= default_count;
    end
    else if (up_press || down_press)
    begin
      if (interval_cnt == '0)
      begin
        // Step now, next one step_interval cycles later
        interval_cnt <= cnt_w'(step_interval - 1);
        period_count <= up_press ? faster_count : slower_count;
      end
      else
        interval_cnt <= interval_cnt - 1'b1;
    end
    else
      interval_cnt <= '0;
  end

endmodule

/* hdl/sample_tick_gen.sv */
`timescale 1ns/1ns

module sample_tick_gen (
  input  logic              CLK_50M,
  input  logic              rst_n,
  input  ipod_pkg::period_t period_count,
  output logic              sample_tick
);

  ipod_pkg::period_t tick_cnt;

  // ============================================================
  // Down-counter, one tick per period_count+1 cycles
  // ============================================================

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tick_cnt    <= '0;
      sample_tick <= 1'b0;
    end
    else if (tick_cnt == '0)
    begin
      // Wrap point, the new period is sampled only here
      tick_cnt    <= period_count;
      sample_tick <= 1'b1;
    end
    else
    begin
      tick_cnt    <= tick_cnt - 1'b1;
      sample_tick <= 1'b0;
    end
  end

endmodule

/* hdl/kbd_command_decode.sv */
`timescale 1ns/1ns

module kbd_command_decode (
  input  logic       CLK_50M,
  input  logic       rst_n,
  input  logic [7:0] kbd_ascii,
  input  logic       kbd_strobe,
  output logic       play,
  output logic       backward,
  output logic       restart
);

  // ============================================================
  // Command register
  // ============================================================

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      play     <= 1'b0;
      backward <= 1'b0;
      restart  <= 1'b0;
    end
    else
    begin
      // Restart lasts one cycle only
      restart <= 1'b0;
      if (kbd_strobe)
      begin
        case (kbd_ascii)
          ipod_pkg::ascii_play_upper, ipod_pkg::ascii_play_lower:       play     <= 1'b1;
          ipod_pkg::ascii_pause_upper, ipod_pkg::ascii_pause_lower:     play     <= 1'b0;
          ipod_pkg::ascii_back_upper, ipod_pkg::ascii_back_lower:       backward <= 1'b1;
          ipod_pkg::ascii_fwd_upper, ipod_pkg::ascii_fwd_lower:         backward <= 1'b0;
          ipod_pkg::ascii_restart_upper, ipod_pkg::ascii_restart_lower: restart  <= 1'b1;
          // Anything else leaves the state alone
          default: ;
        endcase
      end
    end
  end

endmodule

/* hdl/flash_sample_reader.sv */
`timescale 1ns/1ns

module flash_sample_reader #(
  parameter ipod_pkg::flash_addr_t last_addr = 23'h7FFFF
) (
  input  logic                  CLK_50M,
  input  logic                  rst_n,
  input  logic                  sample_tick,
  input  logic                  play,
  input  logic                  backward,
  input  logic                  restart,
  output logic                  flash_read,
  output ipod_pkg::flash_addr_t flash_address,
  input  logic                  flash_waitrequest,
  input  logic [31:0]           flash_readdata,
  input  logic                  flash_readdatavalid,
  output ipod_pkg::sample_t     audio_sample,
  output logic                  sample_strobe
);

  localparam logic [1:0] st_idle    = 2'd0;
  localparam logic [1:0] st_request = 2'd1;
  localparam logic [1:0] st_await   = 2'd2;
  localparam logic [1:0] st_emit    = 2'd3;

  logic [1:0]            state;
  ipod_pkg::flash_addr_t addr;
  ipod_pkg::flash_addr_t next_addr;
  ipod_pkg::flash_addr_t restart_addr;
  ipod_pkg::flash_word_u word_buf;
  logic                  word_valid;
  logic                  half_idx;
  logic                  dir;
  logic                  advance;
  logic                  restart_pend;
  logic                  start_fetch;
  logic                  take;
  logic                  last_half;

  // Address stays stable while a request is held
  assign flash_read    = (state == st_request);
  assign flash_address = addr;

  // Neighbour word in the direction asked for now
  always_comb
  begin
    if (backward)
      next_addr = (addr == '0) ? last_addr : addr - 1'b1;
    else
      next_addr = (addr == last_addr) ? '0 : addr + 1'b1;
    restart_addr = backward ? last_addr : '0;
  end

  assign start_fetch = (state == st_idle) && sample_tick && play && !word_valid && !restart;
  assign take = !restart && play &&
                (((state == st_idle) && sample_tick && word_valid) || (state == st_emit));
  // Second half in the order the word was started with
  assign last_half = half_idx ^ dir;

  // ============================================================
  // Fetch FSM and sample buffer
  // ============================================================

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state         <= st_idle;
      addr          <= '0;
      word_valid    <= 1'b0;
      half_idx      <= 1'b0;
      dir           <= 1'b0;
      advance       <= 1'b0;
      restart_pend  <= 1'b0;
      audio_sample  <= '0;
      sample_strobe <= 1'b0;
    end
    else
    begin
      sample_strobe <= take;

      if (take)
      begin
        audio_sample <= word_buf.halves[half_idx][15:8];
        if (last_half)
        begin
          // Word used up, move on at the next fetch
          word_valid <= 1'b0;
          advance    <= 1'b1;
        end
        else
          half_idx <= ~half_idx;
      end

      case (state)
        st_idle:
          if (start_fetch)
          begin
            if (advance)
              addr <= next_addr;
            advance <= 1'b0;
            dir     <= backward;
            state   <= st_request;
          end
        st_request:
          if (!flash_waitrequest)
            state <= st_await;
        st_await:
          if (flash_readdatavalid)
          begin
            if (restart_pend || restart)
            begin
              // Data belongs to the old position
              addr         <= restart_addr;
              advance      <= 1'b0;
              restart_pend <= 1'b0;
              state        <= st_idle;
            end
            else
            begin
              word_buf.raw <= flash_readdata;
              word_valid   <= 1'b1;
              half_idx     <= dir;
              state        <= st_emit;
            end
          end
        default:
          state <= st_idle;
      endcase

      // Restart overrides the buffer unless a read is in flight
      if (restart && (state == st_idle || state == st_emit))
      begin
        addr       <= restart_addr;
        word_valid <= 1'b0;
        advance    <= 1'b0;
      end
      else if (restart && state == st_request)
        restart_pend <= 1'b1;
      else if (restart && state == st_await && !flash_readdatavalid)
        restart_pend <= 1'b1;
    end
  end

endmodule

/* hdl/hex_display.sv */
`timescale 1ns/1ns

module hex_display #(
  parameter int unsigned refresh_cycles = 25_000_000
) (
  input  logic              CLK_50M,
  input  logic              rst_n,
  input  ipod_pkg::period_t period_count,
  output logic [5:0][6:0]   hex
);

  localparam int cnt_w = $clog2(refresh_cycles + 1);

  logic [cnt_w-1:0]  refresh_cnt;
  ipod_pkg::period_t shown_count;

  // Active-low segments, bit 0 is segment a
  function automatic logic [6:0] seg_decode(input logic [3:0] nibble);
    case (nibble)
      4'h0: seg_decode = 7'h40;
      4'h1: seg_decode = 7'h79;
      4'h2: seg_decode = 7'h24;
      4'h3: seg_decode = 7'h30;
      4'h4: seg_decode = 7'h19;
      4'h5: seg_decode = 7'h12;
      4'h6: seg_decode = 7'h02;
      4'h7: seg_decode = 7'h78;
      4'h8: seg_decode = 7'h00;
      4'h9: seg_decode = 7'h10;
      4'hA: seg_decode = 7'h08;
      4'hB: seg_decode = 7'h03;
      4'hC: seg_decode = 7'h46;
      4'hD: seg_decode = 7'h21;
      4'hE: seg_decode = 7'h06;
      default: seg_decode = 7'h0E;
    endcase
  endfunction

  // ============================================================
  // Refresh latch and digit drivers
  // ============================================================

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      refresh_cnt <= '0;
      shown_count <= '0;
      hex         <= {6{7'h40}};
    end
    else
    begin
      // Latch at count zero, the first one right after reset
      if (refresh_cnt == '0)
        shown_count <= period_count;
      refresh_cnt <= (refresh_cnt == cnt_w'(refresh_cycles - 1)) ? '0 : refresh_cnt + 1'b1;
      for (int d = 0; d < 6; d++)
        hex[d] <= seg_decode(shown_count[d*4 +: 4]);
    end
  end

endmodule

/* hdl/ipod_top.sv */
`timescale 1ns/1ns

module ipod_top #(
  parameter ipod_pkg::flash_addr_t last_addr      = 23'h7FFFF,
  parameter ipod_pkg::period_t     default_count  = 24'd2267,
  parameter ipod_pkg::period_t     speed_step     = 24'd100,
  parameter ipod_pkg::period_t     min_count      = 24'd100,
  parameter ipod_pkg::period_t     max_count      = 24'd20000,
  parameter int unsigned           step_interval  = 5_000_000,
  parameter int unsigned           refresh_cycles = 25_000_000
) (
  input  logic                  CLK_50M,
  input  logic                  rst_n,
  input  logic [2:0]            key,
  input  logic [7:0]            kbd_ascii,
  input  logic                  kbd_strobe,
  output logic                  flash_read,
  output ipod_pkg::flash_addr_t flash_address,
  input  logic                  flash_waitrequest,
  input  logic [31:0]           flash_readdata,
  input  logic                  flash_readdatavalid,
  output ipod_pkg::sample_t     audio_sample,
  output logic                  sample_strobe,
  output logic [5:0][6:0]       hex
);

  ipod_pkg::period_t period_count;
  logic              sample_tick;
  logic              play;
  logic              backward;
  logic              restart;

  // ============================================================
  // Rate control
  // ============================================================

  speed_control #(
    .default_count (default_count),
    .speed_step    (speed_step),
    .min_count     (min_count),
    .max_count     (max_count),
    .step_interval (step_interval)
  ) u_speed_control (
    .CLK_50M      (CLK_50M),
    .rst_n        (rst_n),
    .key          (key),
    .period_count (period_count)
  );

  sample_tick_gen u_sample_tick_gen (
    .CLK_50M      (CLK_50M),
    .rst_n        (rst_n),
    .period_count (period_count),
    .sample_tick  (sample_tick)
  );

  // ============================================================
  // Playback path
  // ============================================================

  kbd_command_decode u_kbd_command_decode (
    .CLK_50M    (CLK_50M),
    .rst_n      (rst_n),
    .kbd_ascii  (kbd_ascii),
    .kbd_strobe (kbd_strobe),
    .play       (play),
    .backward   (backward),
    .restart    (restart)
  );

  flash_sample_reader #(
    .last_addr (last_addr)
  ) u_flash_sample_reader (
    .CLK_50M             (CLK_50M),
    .rst_n               (rst_n),
    .sample_tick         (sample_tick),
    .play                (play),
    .backward            (backward),
    .restart             (restart),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .audio_sample        (audio_sample),
    .sample_strobe       (sample_strobe)
  );

  hex_display #(
    .refresh_cycles (refresh_cycles)
  ) u_hex_display (
    .CLK_50M      (CLK_50M),
    .rst_n        (rst_n),
    .period_count (period_count),
    .hex          (hex)
  );

endmodule

/* tests/tb_ipod.sv */
`timescale 1ns/1ns

module tb_ipod;

  localparam int last_addr      = 7;
  localparam int default_count  = 40;
  localparam int speed_step     = 4;
  localparam int min_count      = 8;
  localparam int max_count      = 80;
  localparam int step_interval  = 200;
  localparam int refresh_cycles = 64;

  logic                  CLK_50M;
  logic                  rst_n;
  logic [2:0]            key;
  logic [7:0]            kbd_ascii;
  logic                  kbd_strobe;
  logic                  flash_read;
  ipod_pkg::flash_addr_t flash_address;
  logic                  flash_waitrequest;
  logic [31:0]           flash_readdata;
  logic                  flash_readdatavalid;
  ipod_pkg::sample_t     audio_sample;
  logic                  sample_strobe;
  logic [5:0][6:0]       hex;

  logic [31:0]     patterns [0:63];
  int              seed = 32'h11aea108;
  int              mismatch_count = 0;
  int              failure_count = 0;
  longint unsigned watchdog_ns = 0;

  // Reference model of the playback position
  int m_addr = 0;
  bit m_pos = 1'b0;
  bit m_dir = 1'b0;
  bit m_valid = 1'b0;
  bit m_advance = 1'b0;
  bit m_backward = 1'b0;

  ipod_top #(
    .last_addr      (23'd7),
    .default_count  (24'd40),
    .speed_step     (24'd4),
    .min_count      (24'd8),
    .max_count      (24'd80),
    .step_interval  (200),
    .refresh_cycles (64)
  ) DUT (
    .CLK_50M             (CLK_50M),
    .rst_n               (rst_n),
    .key                 (key),
    .kbd_ascii           (kbd_ascii),
    .kbd_strobe          (kbd_strobe),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .audio_sample        (audio_sample),
    .sample_strobe       (sample_strobe),
    .hex                 (hex)
  );

  initial
  begin
    CLK_50M = 1'b0;
    forever #10 CLK_50M = ~CLK_50M;
  end

  // ============================================================
  // Flash model with a random wait and data two cycles later
  // ============================================================

  initial
  begin : flash_model
    int         hold;
    logic [2:0] word_index;
    flash_waitrequest   = 1'b1;
    flash_readdatavalid = 1'b0;
    flash_readdata      = '0;
    forever
    begin
      @(posedge CLK_50M);
      #2;
      if (rst_n && flash_read)
      begin
        hold = $unsigned($random(seed)) % 3;
        repeat (hold)
        begin
          @(posedge CLK_50M);
          #2;
        end
        if (flash_address > 23'(last_addr))
        begin
          $display("Flash read at %0t outside the image, address %h", $time, flash_address);
          failure_count++;
        end
        word_index = flash_address[2:0];
        flash_waitrequest = 1'b0;
        @(posedge CLK_50M);
        #2;
        flash_waitrequest = 1'b1;
        @(posedge CLK_50M);
        #2;
        flash_readdatavalid = 1'b1;
        flash_readdata      = patterns[word_index];
        @(posedge CLK_50M);
        #2;
        flash_readdatavalid = 1'b0;
      end
    end
  end

  initial
  begin : watchdog
    wait (watchdog_ns != 0);
    #(watchdog_ns);
    $display("Watchdog expired at %0t before the tests finished", $time);
    $display("TB FAILED");
    $finish;
  end

  // ============================================================
  // Expected values
  // ============================================================

  task automatic predict_sample(output logic [7:0] value);
    logic [31:0] word;
    if (!m_valid)
    begin
      if (m_advance && m_backward)
        m_addr = (m_addr == 0) ? last_addr : m_addr - 1;
      else if (m_advance)
        m_addr = (m_addr == last_addr) ? 0 : m_addr + 1;
      m_dir     = m_backward;
      m_pos     = 1'b0;
      m_valid   = 1'b1;
      m_advance = 1'b0;
    end
    word  = patterns[m_addr];
    // Forward plays the low half first, backward the high half
    value = (m_pos ^ m_dir) ? word[31:24] : word[15:8];
    if (m_pos)
    begin
      m_valid   = 1'b0;
      m_advance = 1'b1;
    end
    else
      m_pos = 1'b1;
  endtask

  function automatic logic [6:0] digit_segments(input logic [3:0] nibble);
    logic [6:0] lit;
    case (nibble)
      4'h0: lit = 7'h3F;
      4'h1: lit = 7'h06;
      4'h2: lit = 7'h5B;
      4'h3: lit = 7'h4F;
      4'h4: lit = 7'h66;
      4'h5: lit = 7'h6D;
      4'h6: lit = 7'h7D;
      4'h7: lit = 7'h07;
      4'h8: lit = 7'h7F;
      4'h9: lit = 7'h6F;
      4'hA: lit = 7'h77;
      4'hB: lit = 7'h7C;
      4'hC: lit = 7'h39;
      4'hD: lit = 7'h5E;
      4'hE: lit = 7'h79;
      default: lit = 7'h71;
    endcase
    // Segments are lit by a low level
    return ~lit;
  endfunction

  function automatic int stepped_count(input int start, input int cycles, input bit faster);
    int count;
    int steps;
    count = start;
    // One step at once and one more per full interval held
    steps = (cycles - 1) / step_interval + 1;
    for (int i = 0; i < steps; i++)
    begin
      if (faster)
        count = (count - speed_step < min_count) ? min_count : count - speed_step;
      else
        count = (count + speed_step > max_count) ? max_count : count + speed_step;
    end
    return count;
  endfunction

  // ============================================================
  // Stimulus and checks
  // ============================================================

  task automatic send_command(input logic [7:0] code);
    @(posedge CLK_50M);
    #2;
    kbd_ascii  = code;
    kbd_strobe = 1'b1;
    @(posedge CLK_50M);
    #2;
    kbd_strobe = 1'b0;
  endtask

  task automatic collect_samples(input int count);
    int         waited;
    logic [7:0] expected;
    for (int i = 0; i < count; i++)
    begin
      waited = 0;
      @(negedge CLK_50M);
      while (!sample_strobe && waited < max_count + 10)
      begin
        @(negedge CLK_50M);
        waited++;
      end
      if (!sample_strobe)
      begin
        $display("No sample_strobe at %0t within one sample period", $time);
        failure_count++;
        return;
      end
      predict_sample(expected);
      if (audio_sample !== expected)
      begin
        $display("MISMATCH time=%0t signal=audio_sample expected=%h actual=%h",
                 $time, expected, audio_sample);
        mismatch_count++;
      end
    end
  endtask

  task automatic check_paused(input int cycles);
    logic [7:0] held;
    @(negedge CLK_50M);
    held = audio_sample;
    for (int i = 0; i < cycles; i++)
    begin
      if (sample_strobe)
      begin
        $display("sample_strobe pulsed at %0t while playback was paused", $time);
        failure_count++;
      end
      if (audio_sample !== held)
      begin
        $display("MISMATCH time=%0t signal=audio_sample expected=%h actual=%h",
                 $time, held, audio_sample);
        mismatch_count++;
      end
      @(negedge CLK_50M);
    end
  endtask

  task automatic press_key(input int index, input int cycles);
    @(posedge CLK_50M);
    #2;
    key[index] = 1'b0;
    repeat (cycles) @(posedge CLK_50M);
    #2;
    key[index] = 1'b1;
  endtask

  task automatic check_display(input int value);
    logic [5:0][6:0] expected;
    logic [23:0]     shown;
    repeat (2 * refresh_cycles) @(posedge CLK_50M);
    @(negedge CLK_50M);
    shown = 24'(value);
    for (int d = 0; d < 6; d++)
      expected[d] = digit_segments(shown[d*4 +: 4]);
    if (hex !== expected)
    begin
      $display("MISMATCH time=%0t signal=hex expected=%h actual=%h", $time, expected, hex);
      mismatch_count++;
    end
  endtask

  initial
  begin : main
    int         step_total;
    int         sample_total;
    int         count;
    logic [7:0] code;
    key        = 3'b111;
    kbd_ascii  = 8'h00;
    kbd_strobe = 1'b0;
    rst_n      = 1'b0;
    $readmemh("tests/ipod_patterns.txt", patterns);
    step_total   = patterns[8];
    sample_total = 0;
    for (int s = 0; s < step_total; s++)
      sample_total += int'(patterns[9 + s][7:0]);
    watchdog_ns = longint'(sample_total) * (max_count + 10) * 20 + 50_000;

    repeat (8) @(posedge CLK_50M);
    #2;
    rst_n = 1'b1;
    check_display(default_count);

    for (int s = 0; s < step_total; s++)
    begin
      code  = patterns[9 + s][15:8];
      count = int'(patterns[9 + s][7:0]);
      send_command(code);
      case (code)
        "B", "b": m_backward = 1'b1;
        "F", "f": m_backward = 1'b0;
        "R", "r":
        begin
          m_addr    = m_backward ? last_addr : 0;
          m_valid   = 1'b0;
          m_advance = 1'b0;
        end
        default: ;
      endcase
      if (code == "D" || code == "d")
        check_paused(5 * max_count);
      else
        collect_samples(count);
    end

    // Speed keys and the digits after each change
    count = stepped_count(default_count, 20, 1'b1);
    press_key(0, 20);
    check_display(count);
    count = stepped_count(count, 1201, 1'b0);
    press_key(1, 1201);
    check_display(count);
    press_key(2, 20);
    check_display(default_count);

    $display("Errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
    if (mismatch_count == 0 && failure_count == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

/* ipod.f */
hdl/ipod_pkg.sv
hdl/speed_control.sv
hdl/sample_tick_gen.sv
hdl/kbd_command_decode.sv
hdl/flash_sample_reader.sv
hdl/hex_display.sv
hdl/ipod_top.sv
tests/tb_ipod.sv

/* run_ipod.sh */
#!/bin/sh
# Build and run the ipod playback testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_ipod -f ipod.f -o tb_ipod_sim
./obj_dir/tb_ipod_sim > sim.log
cat sim.log

if grep -q "^TB PASSED$" sim.log
then
  exit 0
fi
exit 1

/* tests/ipod_patterns.txt */
// Lines 0-7: flash image, one 32-bit readdata word per word address 0-7
// Line 8: number of steps; each step after it: key code in [15:8], samples to collect in [7:0]
81370C55
92A41B66
A3B52A77
B4C63988
C5D74899
D6E857AA
E7F966BB
F80A75CC
0000000B
00004514
00006214
00004400
00006506
00005206
00004603
00007205
00004203
00006602
00005A04
00004400
